// ==== hw/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// instruction memory depth, in 32-bit words
`define CPU_IMEM_WORDS 64

// data memory depth in words
// byte addresses wrap modulo this size
`define CPU_DMEM_WORDS 32

`endif

// ==== hw/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  // rv32i major opcodes in the supported subset
  typedef enum logic [6:0] {
    op_load   = 7'b0000011,
    op_imm    = 7'b0010011,
    op_store  = 7'b0100011,
    op_reg    = 7'b0110011,
    op_branch = 7'b1100011
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt
  } alu_op_e;

  typedef enum logic [1:0] {
    fwd_none,
    fwd_mem,
    fwd_wb
  } fwd_sel_e;

  // all zero is a no-op
  typedef struct packed {
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    logic       is_branch;
    logic       branch_ne;
    logic       alu_src_imm;
    alu_op_e    alu_op;
    logic [4:0] rd;
  } control_t;

endpackage

`default_nettype wire

// ==== hw/fwd_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// results of the memory and writeback stages, fed back to execute
interface fwd_if;

  logic        mem_reg_write;
  logic [4:0]  mem_rd;
  logic [31:0] mem_data;  // alu result, not load data
  logic        wb_reg_write;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;

  modport src (output mem_reg_write, mem_rd, mem_data, wb_reg_write, wb_rd, wb_data);
  modport unit (input mem_reg_write, mem_rd, wb_reg_write, wb_rd);
  modport exec (input mem_data, wb_data);

endinterface

`default_nettype wire

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module fetch_stage (
  input  logic        sys_clk,
  input  logic        reset,
  input  logic        run,
  input  logic        load_valid,
  input  logic [5:0]  load_addr,
  input  logic [31:0] load_data,
  input  logic        stall,
  input  logic        branch_taken,
  input  logic [31:0] pc_branch,
  output logic [31:0] pc,
  output logic [31:0] instruction
);

  localparam int IAW = $clog2(`CPU_IMEM_WORDS);

  logic [31:0] imem [`CPU_IMEM_WORDS];

  // program load, only while halted
  always_ff @(posedge sys_clk) begin
    if (load_valid && !run) begin
      imem[load_addr[IAW-1:0]] <= load_data;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (reset || !run) begin
      pc <= '0;
    end else if (branch_taken) begin  // redirect beats the stall
      pc <= pc_branch;
    end else if (!stall) begin
      pc <= pc + 32'd4;
    end
  end

  // no-op while halted
  assign instruction = run ? imem[pc[IAW+1:2]] : '0;

endmodule

`default_nettype wire

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic              sys_clk,
  input  logic              reset,
  input  logic [31:0]       instruction,
  input  logic              reg_write,
  input  logic [4:0]        write_id,
  input  logic [31:0]       write_data,
  output cpu_pkg::control_t control,
  output logic [31:0]       read1_data,
  output logic [31:0]       read2_data,
  output logic [31:0]       immediate_data,
  output logic [4:0]        rs1,
  output logic [4:0]        rs2
);

  logic [31:0] regs [32];
  logic [2:0]  funct3;
  logic [4:0]  rd;
  logic        uses_rs1;
  logic        uses_rs2;

  // write-through so writeback is seen the same cycle
  function automatic logic [31:0] read_reg(input logic [4:0] idx);
    if (idx == 5'd0) return '0;
    if (reg_write && write_id == idx) return write_data;
    return regs[idx];
  endfunction

  assign funct3 = instruction[14:12];
  assign rd     = instruction[11:7];

  always_comb begin
    control        = '0;
    immediate_data = '0;
    uses_rs1       = 1'b0;
    uses_rs2       = 1'b0;
    case (instruction[6:0])
      cpu_pkg::op_reg: begin
        uses_rs1          = 1'b1;
        uses_rs2          = 1'b1;
        control.reg_write = 1'b1;
        control.rd        = rd;
        case (funct3)
          3'b000:  control.alu_op = instruction[30] ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
          3'b010:  control.alu_op = cpu_pkg::alu_slt;
          3'b100:  control.alu_op = cpu_pkg::alu_xor;
          3'b110:  control.alu_op = cpu_pkg::alu_or;
          3'b111:  control.alu_op = cpu_pkg::alu_and;
          default: control.reg_write = 1'b0;  // outside the subset
        endcase
      end
      cpu_pkg::op_imm, cpu_pkg::op_load: begin
        if (funct3 == (instruction[4] ? 3'b000 : 3'b010)) begin  // addi or lw
          uses_rs1            = 1'b1;
          control.reg_write   = 1'b1;
          control.mem_read    = !instruction[4];
          control.alu_src_imm = 1'b1;
          control.rd          = rd;
          immediate_data      = {{20{instruction[31]}}, instruction[31:20]};
        end
      end
      cpu_pkg::op_store: begin
        if (funct3 == 3'b010) begin
          uses_rs1            = 1'b1;
          uses_rs2            = 1'b1;
          control.mem_write   = 1'b1;
          control.alu_src_imm = 1'b1;
          immediate_data      = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
        end
      end
      cpu_pkg::op_branch: begin
        if (funct3[2:1] == 2'b00) begin  // beq, bne
          uses_rs1          = 1'b1;
          uses_rs2          = 1'b1;
          control.is_branch = 1'b1;
          control.branch_ne = funct3[0];
          immediate_data    = {{20{instruction[31]}}, instruction[7], instruction[30:25],
                               instruction[11:8], 1'b0};
        end
      end
      default: ;
    endcase
    if (control.rd == 5'd0) control.reg_write = 1'b0;  // x0 stays zero
  end

  // unused sources read as x0 so they never stall or forward
  assign rs1 = uses_rs1 ? instruction[19:15] : 5'd0;
  assign rs2 = uses_rs2 ? instruction[24:20] : 5'd0;

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_write && write_id != 5'd0) begin
      regs[write_id] <= write_data;
    end
  end

  always_comb begin
    read1_data = read_reg(rs1);
    read2_data = read_reg(rs2);
  end

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  logic [31:0]       data1,
  input  logic [31:0]       data2,
  input  logic [31:0]       immediate_data,
  input  logic [31:0]       pc_execute,
  input  cpu_pkg::control_t control,
  input  cpu_pkg::fwd_sel_e fwd_sel_a,
  input  cpu_pkg::fwd_sel_e fwd_sel_b,
  fwd_if.exec               fwd,
  output logic [31:0]       alu_res,
  output logic [31:0]       store_data,
  output logic              branch_taken,
  output logic [31:0]       pc_branch
);

  logic [31:0] operand_a;
  logic [31:0] operand_b;
  logic [31:0] alu_b;

  function automatic logic [31:0] pick(input cpu_pkg::fwd_sel_e sel,
                                       input logic [31:0] reg_val,
                                       input logic [31:0] mem_val,
                                       input logic [31:0] wb_val);
    case (sel)
      cpu_pkg::fwd_mem: return mem_val;
      cpu_pkg::fwd_wb:  return wb_val;
      default:          return reg_val;
    endcase
  endfunction

  assign operand_a = pick(fwd_sel_a, data1, fwd.mem_data, fwd.wb_data);
  assign operand_b = pick(fwd_sel_b, data2, fwd.mem_data, fwd.wb_data);
  assign alu_b     = control.alu_src_imm ? immediate_data : operand_b;

  always_comb begin
    case (control.alu_op)
      cpu_pkg::alu_sub: alu_res = operand_a - alu_b;
      cpu_pkg::alu_and: alu_res = operand_a & alu_b;
      cpu_pkg::alu_or:  alu_res = operand_a | alu_b;
      cpu_pkg::alu_xor: alu_res = operand_a ^ alu_b;
      cpu_pkg::alu_slt: alu_res = {31'd0, $signed(operand_a) < $signed(alu_b)};
      default:          alu_res = operand_a + alu_b;
    endcase
  end

  assign store_data = operand_b;  // forwarded rs2 for sw

  // beq / bne on forwarded operands
  assign branch_taken = control.is_branch &&
                        (control.branch_ne ? (operand_a != operand_b) : (operand_a == operand_b));
  assign pc_branch    = pc_execute + immediate_data;

endmodule

`default_nettype wire

// ==== hw/memory_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module memory_stage (
  input  logic              sys_clk,
  input  logic              reset,
  input  logic [31:0]       alu_res_in,
  input  logic [31:0]       store_data_in,
  input  cpu_pkg::control_t control,
  output logic [31:0]       load_data
);

  localparam int DAW = $clog2(`CPU_DMEM_WORDS);

  logic [31:0]    dmem [`CPU_DMEM_WORDS];
  logic [DAW-1:0] word_addr;

  assign word_addr = alu_res_in[DAW+1:2];  // wraps modulo depth

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      for (int i = 0; i < `CPU_DMEM_WORDS; i++) begin
        dmem[i] <= '0;
      end
    end else if (control.mem_write) begin
      dmem[word_addr] <= store_data_in;
    end
  end

  assign load_data = dmem[word_addr];

endmodule

`default_nettype wire

// ==== hw/hazard_forward_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_forward_unit (
  input  logic [4:0]        rs1_decode,
  input  logic [4:0]        rs2_decode,
  input  logic [4:0]        rs1_execute,
  input  logic [4:0]        rs2_execute,
  input  cpu_pkg::control_t control_ex,
  fwd_if.unit               fwd,
  output logic              stall,
  output cpu_pkg::fwd_sel_e fwd_sel_a,
  output cpu_pkg::fwd_sel_e fwd_sel_b
);

  // youngest writer wins, x0 never forwarded
  function automatic cpu_pkg::fwd_sel_e select_src(input logic [4:0] rs,
                                                   input logic       mem_we,
                                                   input logic [4:0] mem_rd,
                                                   input logic       wb_we,
                                                   input logic [4:0] wb_rd);
    if (rs == 5'd0) return cpu_pkg::fwd_none;
    if (mem_we && mem_rd == rs) return cpu_pkg::fwd_mem;
    if (wb_we && wb_rd == rs) return cpu_pkg::fwd_wb;
    return cpu_pkg::fwd_none;
  endfunction

  // load in execute feeding decode
  assign stall = control_ex.mem_read && control_ex.rd != 5'd0 &&
                 (control_ex.rd == rs1_decode || control_ex.rd == rs2_decode);

  assign fwd_sel_a = select_src(rs1_execute, fwd.mem_reg_write, fwd.mem_rd,
                                fwd.wb_reg_write, fwd.wb_rd);
  assign fwd_sel_b = select_src(rs2_execute, fwd.mem_reg_write, fwd.mem_rd,
                                fwd.wb_reg_write, fwd.wb_rd);

endmodule

`default_nettype wire

// ==== hw/pipeline_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeline_top (
  input  logic        sys_clk,
  input  logic        reset,
  input  logic        load_valid,
  input  logic [5:0]  load_addr,
  input  logic [31:0] load_data,
  input  logic        run,
  output logic        retire_valid,
  output logic [4:0]  retire_rd,
  output logic [31:0] retire_data,
  output logic        store_valid,
  output logic [31:0] store_addr,
  output logic [31:0] store_data
);

  logic [31:0]       pc_fetch, instruction_fetch;
  logic              stall;

  logic [31:0]       instruction_decode, pc_decode;
  cpu_pkg::control_t control_decode;
  logic [31:0]       read1_data_decode, read2_data_decode, immediate_data_decode;
  logic [4:0]        rs1_decode, rs2_decode;

  cpu_pkg::control_t control_execute;
  logic [31:0]       pc_execute, data1_execute, data2_execute, immediate_data_execute;
  logic [4:0]        rs1_execute, rs2_execute;
  cpu_pkg::fwd_sel_e fwd_sel_a, fwd_sel_b;
  logic [31:0]       alu_res_execute, store_data_execute, pc_branch_execute;
  logic              branch_taken_execute;

  cpu_pkg::control_t control_mem, control_mem_gated;
  logic [31:0]       alu_res_mem, store_data_mem, pc_branch_mem, load_data_mem;
  logic              branch_taken_mem;

  cpu_pkg::control_t control_wb;
  logic [31:0]       alu_res_wb, load_data_wb, wb_data;
  logic              wb_write;

  fwd_if fwd ();

  // control registers, cleared on reset and while halted
  always_ff @(posedge sys_clk) begin
    if (reset || !run) begin
      instruction_decode <= '0;
      control_execute    <= '0;
      control_mem        <= '0;
      branch_taken_mem   <= 1'b0;
      control_wb         <= '0;
    end else begin
      if (branch_taken_mem) begin
        instruction_decode <= '0;  // squash
      end else if (!stall) begin
        instruction_decode <= instruction_fetch;
      end
      // bubble on load-use
      control_execute  <= (branch_taken_mem || stall) ? '0 : control_decode;
      control_mem      <= branch_taken_mem ? '0 : control_execute;
      branch_taken_mem <= branch_taken_mem ? 1'b0 : branch_taken_execute;
      control_wb       <= control_mem;
    end
  end

  // payload
  always_ff @(posedge sys_clk) begin
    if (!stall) pc_decode <= pc_fetch;
    pc_execute             <= pc_decode;
    data1_execute          <= read1_data_decode;
    data2_execute          <= read2_data_decode;
    immediate_data_execute <= immediate_data_decode;
    rs1_execute            <= rs1_decode;
    rs2_execute            <= rs2_decode;
    alu_res_mem            <= alu_res_execute;
    store_data_mem         <= store_data_execute;
    pc_branch_mem          <= pc_branch_execute;
    alu_res_wb             <= alu_res_mem;
    load_data_wb           <= load_data_mem;
  end

  always_comb begin
    control_mem_gated           = control_mem;
    control_mem_gated.mem_write = control_mem.mem_write & run;
  end

  assign wb_data  = control_wb.mem_read ? load_data_wb : alu_res_wb;
  assign wb_write = control_wb.reg_write & run;

  assign fwd.mem_reg_write = control_mem.reg_write;
  assign fwd.mem_rd        = control_mem.rd;
  assign fwd.mem_data      = alu_res_mem;
  assign fwd.wb_reg_write  = wb_write;
  assign fwd.wb_rd         = control_wb.rd;
  assign fwd.wb_data       = wb_data;

  fetch_stage fetch_inst (
    .sys_clk(sys_clk), .reset(reset), .run(run),
    .load_valid(load_valid), .load_addr(load_addr), .load_data(load_data),
    .stall(stall), .branch_taken(branch_taken_mem), .pc_branch(pc_branch_mem),
    .pc(pc_fetch), .instruction(instruction_fetch)
  );

  decode_stage decode_inst (
    .sys_clk(sys_clk), .reset(reset), .instruction(instruction_decode),
    .reg_write(wb_write), .write_id(control_wb.rd), .write_data(wb_data),
    .control(control_decode), .read1_data(read1_data_decode),
    .read2_data(read2_data_decode), .immediate_data(immediate_data_decode),
    .rs1(rs1_decode), .rs2(rs2_decode)
  );

  hazard_forward_unit hazard_inst (
    .rs1_decode(rs1_decode), .rs2_decode(rs2_decode),
    .rs1_execute(rs1_execute), .rs2_execute(rs2_execute),
    .control_ex(control_execute), .fwd(fwd),
    .stall(stall), .fwd_sel_a(fwd_sel_a), .fwd_sel_b(fwd_sel_b)
  );

  execute_stage execute_inst (
    .data1(data1_execute), .data2(data2_execute),
    .immediate_data(immediate_data_execute), .pc_execute(pc_execute),
    .control(control_execute), .fwd_sel_a(fwd_sel_a), .fwd_sel_b(fwd_sel_b), .fwd(fwd),
    .alu_res(alu_res_execute), .store_data(store_data_execute),
    .branch_taken(branch_taken_execute), .pc_branch(pc_branch_execute)
  );

  memory_stage memory_inst (
    .sys_clk(sys_clk), .reset(reset), .alu_res_in(alu_res_mem),
    .store_data_in(store_data_mem), .control(control_mem_gated),
    .load_data(load_data_mem)
  );

  // observation ports
  assign retire_valid = wb_write;
  assign retire_rd    = control_wb.rd;
  assign retire_data  = wb_data;
  assign store_valid  = control_mem_gated.mem_write;
  assign store_addr   = alu_res_mem;
  assign store_data   = store_data_mem;

endmodule

`default_nettype wire

// ==== tb/pipeline_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeline_asserts (
  input logic sys_clk,
  input logic reset,
  input logic run,
  input logic retire_valid,
  input logic [4:0] retire_rd,
  input logic store_valid,
  input logic stall,
  input logic branch_taken_mem
);

  retire_rd_nonzero: assert property (@(posedge sys_clk) disable iff (reset)
    retire_valid |-> retire_rd != 5'd0)
    else $error("register write retired to x0");

  // nothing observable while halted
  halted_quiet: assert property (@(posedge sys_clk) disable iff (reset)
    !run |-> !retire_valid && !store_valid)
    else $error("retire or store seen while run is low");

  // branch itself, then the three squashed slots reach writeback
  flush_no_write: assert property (@(posedge sys_clk) disable iff (reset)
    branch_taken_mem |=> !retire_valid [*4])
    else $error("squashed slot wrote a register after a branch");

  flush_no_store: assert property (@(posedge sys_clk) disable iff (reset)
    branch_taken_mem |=> !store_valid [*3])
    else $error("squashed slot stored to memory after a branch");

  stall_bubble: assert property (@(posedge sys_clk) disable iff (reset)
    stall |=> ##2 !retire_valid)  // bubble reaches writeback
    else $error("load-use bubble wrote a register");

endmodule

bind pipeline_top pipeline_asserts asserts_inst (
  .sys_clk(sys_clk), .reset(reset), .run(run),
  .retire_valid(retire_valid), .retire_rd(retire_rd), .store_valid(store_valid),
  .stall(stall), .branch_taken_mem(branch_taken_mem)
);

`default_nettype wire

// ==== tb/pipeline_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module pipeline_tb;

  localparam int prog_words   = 40;
  localparam int num_programs = 7;  // three directed, four random
  localparam int cycle_limit  = 16 + 20 + num_programs * (prog_words + 3 * prog_words + 20);

  typedef enum int {
    k_add, k_sub, k_and, k_or, k_xor, k_slt, k_addi, k_lw, k_sw, k_beq, k_bne
  } kind_e;

  logic        sys_clk = 1'b0;
  logic        reset;
  logic        load_valid;
  logic [5:0]  load_addr;
  logic [31:0] load_data;
  logic        run;
  logic        retire_valid;
  logic [4:0]  retire_rd;
  logic [31:0] retire_data;
  logic        store_valid;
  logic [31:0] store_addr;
  logic [31:0] store_data;

  kind_e       p_kind [prog_words];
  logic [4:0]  p_rd [prog_words];
  logic [4:0]  p_rs1 [prog_words];
  logic [4:0]  p_rs2 [prog_words];
  logic [31:0] p_imm [prog_words];
  int          prog_len;

  logic [31:0] model_regs [32];
  logic [31:0] model_dmem [`CPU_DMEM_WORDS];
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_rdata [$];
  logic [31:0] exp_saddr [$];
  logic [31:0] exp_sdata [$];

  int seed        = 99617;
  int error_count = 0;
  int check_count = 0;
  int test_count  = 0;
  int cycle_count = 0;
  int retire_seen;
  int store_seen;
  int retire_total;
  int store_total;

  always #20 sys_clk = ~sys_clk;

  pipeline_top UUT (
    .sys_clk(sys_clk), .reset(reset), .load_valid(load_valid), .load_addr(load_addr),
    .load_data(load_data), .run(run), .retire_valid(retire_valid), .retire_rd(retire_rd),
    .retire_data(retire_data), .store_valid(store_valid), .store_addr(store_addr),
    .store_data(store_data)
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    check_count++;
    if (got !== expected) begin
      error_count++;
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, expected);
    end
  endtask

  function automatic int below(input int n);
    return {$random(seed)} % n;
  endfunction

  // rv32i encodings
  function automatic logic [31:0] encode(input kind_e kind, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [4:0] rs2,
                                         input logic [31:0] imm);
    case (kind)
      k_add:   return {7'h00, rs2, rs1, 3'b000, rd, cpu_pkg::op_reg};
      k_sub:   return {7'h20, rs2, rs1, 3'b000, rd, cpu_pkg::op_reg};
      k_and:   return {7'h00, rs2, rs1, 3'b111, rd, cpu_pkg::op_reg};
      k_or:    return {7'h00, rs2, rs1, 3'b110, rd, cpu_pkg::op_reg};
      k_xor:   return {7'h00, rs2, rs1, 3'b100, rd, cpu_pkg::op_reg};
      k_slt:   return {7'h00, rs2, rs1, 3'b010, rd, cpu_pkg::op_reg};
      k_addi:  return {imm[11:0], rs1, 3'b000, rd, cpu_pkg::op_imm};
      k_lw:    return {imm[11:0], rs1, 3'b010, rd, cpu_pkg::op_load};
      k_sw:    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], cpu_pkg::op_store};
      k_beq:   return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11],
                       cpu_pkg::op_branch};
      default: return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11],
                       cpu_pkg::op_branch};
    endcase
  endfunction

  task automatic add_instr(input kind_e kind, input int rd, input int rs1, input int rs2,
                           input int imm);
    p_kind[prog_len] = kind;
    p_rd[prog_len]   = 5'(rd);
    p_rs1[prog_len]  = 5'(rs1);
    p_rs2[prog_len]  = 5'(rs2);
    p_imm[prog_len]  = imm;
    prog_len++;
  endtask

  task automatic pad_program();
    while (prog_len < prog_words) add_instr(k_beq, 0, 0, 0, 0);  // self-loops
  endtask

  task automatic make_random_program();
    int sel;
    int off;
    prog_len = 0;
    for (int i = 0; i < prog_words - 2; i++) begin
      sel = below(20);
      if (sel < 9) begin
        add_instr(kind_e'(below(6)), below(8), below(8), below(8), 0);
      end else if (sel < 13) begin
        add_instr(k_addi, below(8), below(8), 0, below(129) - 64);
      end else if (sel < 15) begin
        add_instr(k_lw, below(8), 0, 0, 4 * below(16));
      end else if (sel < 17) begin
        add_instr(k_sw, 0, 0, below(8), 4 * below(16));
      end else begin
        off = 1 + below(4);
        if (off > prog_words - 2 - i) off = prog_words - 2 - i;  // stay before the loop
        add_instr(below(2) ? k_beq : k_bne, 0, below(8), below(8), 4 * off);
      end
    end
    pad_program();
  endtask

  // sequential ISA model, state carries over between programs
  task automatic run_model();
    int          pc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] addr;
    bit          taken;
    pc = 0;
    while (pc < prog_len) begin
      a     = model_regs[p_rs1[pc]];
      b     = model_regs[p_rs2[pc]];
      addr  = a + p_imm[pc];
      taken = 1'b0;
      case (p_kind[pc])
        k_add:  res = a + b;
        k_sub:  res = a - b;
        k_and:  res = a & b;
        k_or:   res = a | b;
        k_xor:  res = a ^ b;
        k_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        k_addi: res = addr;
        k_lw:   res = model_dmem[(addr >> 2) % `CPU_DMEM_WORDS];
        k_sw: begin
          model_dmem[(addr >> 2) % `CPU_DMEM_WORDS] = b;
          exp_saddr.push_back(addr);
          exp_sdata.push_back(b);
        end
        k_beq:  taken = (a == b);
        default: taken = (a != b);
      endcase
      if (p_kind[pc] <= k_lw && p_rd[pc] != 5'd0) begin
        model_regs[p_rd[pc]] = res;
        exp_rd.push_back(p_rd[pc]);
        exp_rdata.push_back(res);
      end
      if (taken && p_imm[pc] == 0) break;  // reached the self-loop
      pc = taken ? pc + (p_imm[pc] >> 2) : pc + 1;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    test_count++;
    $display("test %0d %s: %0d errors", test_count, name, error_count - errors_before);
  endtask

  task automatic check_idle();
    int errors_before;
    errors_before = error_count;
    repeat (20) begin
      @(negedge sys_clk);
      check_value("retire_valid", retire_valid, 0);
      check_value("store_valid", store_valid, 0);
    end
    report_test("idle after reset", errors_before);
  endtask

  task automatic run_program(input string name);
    int errors_before;
    errors_before = error_count;
    run_model();
    retire_total = exp_rd.size();
    store_total  = exp_sdata.size();
    retire_seen  = 0;
    store_seen   = 0;
    for (int i = 0; i < prog_words; i++) begin
      @(posedge sys_clk);
      load_valid <= 1'b1;
      load_addr  <= 6'(i);
      load_data  <= encode(p_kind[i], p_rd[i], p_rs1[i], p_rs2[i], p_imm[i]);
    end
    @(posedge sys_clk);
    load_valid <= 1'b0;
    run        <= 1'b1;
    while (retire_seen < retire_total || store_seen < store_total) @(posedge sys_clk);
    repeat (20) @(posedge sys_clk);  // window for stray events
    run <= 1'b0;
    @(posedge sys_clk);
    check_value("retire_count", retire_seen, retire_total);
    check_value("store_count", store_seen, store_total);
    report_test(name, errors_before);
  endtask

  // in-order event monitor
  always @(negedge sys_clk) begin
    if (retire_valid) begin
      if (exp_rd.size() == 0) begin
        error_count++;
        $display("unexpected register write to x%0d beyond the expected list", retire_rd);
      end else begin
        check_value("retire_rd", retire_rd, exp_rd.pop_front());
        check_value("retire_data", retire_data, exp_rdata.pop_front());
      end
      retire_seen++;
    end
    if (store_valid) begin
      if (exp_saddr.size() == 0) begin
        error_count++;
        $display("unexpected store to address 0x%08h beyond the expected list", store_addr);
      end else begin
        check_value("store_addr", store_addr, exp_saddr.pop_front());
        check_value("store_data", store_data, exp_sdata.pop_front());
      end
      store_seen++;
    end
  end

  always @(posedge sys_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    reset      = 1'b1;
    run        = 1'b0;
    load_valid = 1'b0;
    load_addr  = '0;
    load_data  = '0;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    for (int i = 0; i < `CPU_DMEM_WORDS; i++) model_dmem[i] = '0;
    repeat (16) @(posedge sys_clk);
    reset <= 1'b0;

    check_idle();

    prog_len = 0;
    add_instr(k_addi, 1, 0, 0, 5);
    add_instr(k_addi, 2, 1, 0, 7);
    add_instr(k_add, 3, 2, 1, 0);
    add_instr(k_sub, 4, 3, 2, 0);
    add_instr(k_xor, 5, 4, 3, 0);
    add_instr(k_or, 6, 5, 1, 0);
    add_instr(k_and, 7, 6, 4, 0);
    add_instr(k_slt, 1, 4, 7, 0);
    add_instr(k_addi, 2, 1, 0, -9);
    add_instr(k_slt, 3, 2, 1, 0);
    add_instr(k_add, 4, 3, 2, 0);
    pad_program();
    run_program("dependent alu chain");

    prog_len = 0;
    add_instr(k_addi, 1, 0, 0, 42);
    add_instr(k_sw, 0, 0, 1, 8);
    add_instr(k_lw, 2, 0, 0, 8);
    add_instr(k_add, 3, 2, 1, 0);  // load-use
    add_instr(k_lw, 4, 0, 0, 8);
    add_instr(k_sw, 0, 0, 4, 12);
    add_instr(k_lw, 5, 0, 0, 12);
    add_instr(k_addi, 6, 5, 0, 1);
    add_instr(k_lw, 7, 0, 0, 12);
    add_instr(k_sub, 1, 7, 3, 0);
    pad_program();
    run_program("load then use");

    prog_len = 0;
    add_instr(k_addi, 1, 0, 0, 3);
    add_instr(k_addi, 2, 0, 0, 3);
    add_instr(k_beq, 0, 1, 2, 16);  // taken
    add_instr(k_addi, 3, 0, 0, 11);
    add_instr(k_addi, 4, 0, 0, 12);
    add_instr(k_addi, 5, 0, 0, 13);
    add_instr(k_addi, 3, 0, 0, 21);
    add_instr(k_bne, 0, 1, 2, 8);  // not taken
    add_instr(k_addi, 4, 0, 0, 22);
    add_instr(k_addi, 5, 0, 0, 23);
    add_instr(k_addi, 6, 0, 0, 24);
    add_instr(k_bne, 0, 3, 1, 8);
    add_instr(k_addi, 6, 0, 0, 31);
    add_instr(k_addi, 7, 0, 0, 32);
    add_instr(k_beq, 0, 3, 0, 4);
    add_instr(k_addi, 1, 0, 0, 41);
    add_instr(k_beq, 0, 0, 0, 4);
    add_instr(k_addi, 2, 0, 0, 42);
    pad_program();
    run_program("branches and squash");

    for (int n = 0; n < 4; n++) begin
      make_random_program();
      run_program($sformatf("random program %0d", n));
    end

    $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
             error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hw
hw/cpu_pkg.sv
hw/fwd_if.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/hazard_forward_unit.sv
hw/pipeline_top.sv
tb/pipeline_asserts.sv
tb/pipeline_tb.sv

// ==== Bender.yml ====
package:
  name: pipeline_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/cpu_pkg.sv
      - hw/fwd_if.sv
      - hw/fetch_stage.sv
      - hw/decode_stage.sv
      - hw/execute_stage.sv
      - hw/memory_stage.sv
      - hw/hazard_forward_unit.sv
      - hw/pipeline_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - tb/pipeline_asserts.sv
      - tb/pipeline_tb.sv
